// File: hdl/mold_cfg.svh
/*
 * Size macros for the MoldUDP64 parser:
 * beat and window sizes, header field sizes and the end-of-session count
 */
`ifndef MOLD_CFG_SVH
`define MOLD_CFG_SVH

// bytes per AXI beat and per output beat
`define MOLD_BEAT_BYTES 8

// byte window capacity and the number of head bytes it exposes
`define MOLD_WIN_BYTES 16
`define MOLD_HEAD_BYTES 10

// downstream packet header fields, all big-endian
`define MOLD_SID_BYTES 10
`define MOLD_SEQ_BYTES 8
`define MOLD_CNT_BYTES 2
`define MOLD_LEN_BYTES 2

// message count that closes a session
`define MOLD_EOS_CNT 65535

`endif

// File: hdl/mold_pkg.sv
/*
 * Shared types of the MoldUDP64 parser:
 * beat data and lane mask, window head, fill and take counts,
 * session id, sequence number, length, and the sequencer states
 */
`default_nettype none

`include "mold_cfg.svh"

package mold_pkg;

	// one output or input beat, byte lane 0 in the low bits
	typedef logic [`MOLD_BEAT_BYTES*8-1:0] beat_data_t;
	typedef logic [`MOLD_BEAT_BYTES-1:0] beat_mask_t;

	// head of the byte window, wide enough for the session id
	typedef logic [`MOLD_HEAD_BYTES*8-1:0] head_t;

	// 0 to 16 bytes held, 0 to 10 bytes taken in one cycle
	typedef logic [$clog2(`MOLD_WIN_BYTES+1)-1:0] fill_t;
	typedef logic [$clog2(`MOLD_HEAD_BYTES+1)-1:0] take_t;

	typedef logic [`MOLD_SID_BYTES*8-1:0] sid_t;
	typedef logic [`MOLD_SEQ_BYTES*8-1:0] seq_t;

	// message length and message count share one width
	typedef logic [`MOLD_LEN_BYTES*8-1:0] len_t;

	// header fields first, then LEN and PAYLOAD per message
	typedef enum logic [2:0] {
		SID,
		SEQ,
		CNT,
		LEN,
		PAYLOAD
	} seq_state_t;

endpackage

`default_nettype wire

// File: hdl/field_if.sv
/*
 * Field strobe interface between the sequencer and its consumers:
 * header strobes, message chunk strobes, end of session and the
 * current window head, with one modport per consumer
 */
`timescale 1ns/1ps
`default_nettype none

interface field_if;

	import mold_pkg::*;

	// session id and sequence number sit at the window head
	logic sid_v;
	logic seq_v;

	// one chunk of up to 8 message bytes is at the window head
	logic chunk_v;
	take_t chunk_len;
	logic chunk_first;
	logic chunk_last;

	// message count of 65535 seen
	logic eos_v;

	head_t head;

	modport seq (
		output sid_v, seq_v,
		output chunk_v, chunk_len, chunk_first, chunk_last,
		output eos_v,
		output head
	);

	modport tracker (
		input sid_v, seq_v, chunk_last, head
	);

	modport slicer (
		input chunk_v, chunk_len, head
	);

	modport emit (
		input chunk_v, chunk_first, chunk_last, eos_v
	);

endinterface

`default_nettype wire

// File: hdl/byte_window.sv
/*
 * Byte window between the AXI-stream input and the field sequencer.
 * Holds up to 16 bytes with the oldest byte at the head, drops the
 * bytes taken each cycle and appends the kept bytes of an accepted beat
 */
`timescale 1ns/1ps
`default_nettype none

`include "mold_cfg.svh"

module byte_window (
	input wire clk,
	input wire nreset,
	input wire axis_valid_i,
	input wire mold_pkg::beat_mask_t axis_keep_i,
	input wire mold_pkg::beat_data_t axis_data_i,
	input wire mold_pkg::take_t take_i,
	output logic axis_ready_o,
	output mold_pkg::head_t head_o,
	output mold_pkg::fill_t fill_o
);
	import mold_pkg::*;

	localparam int WIN_BITS = `MOLD_WIN_BYTES * 8;
	localparam int BEAT_BITS = `MOLD_BEAT_BYTES * 8;

	logic [WIN_BITS-1:0] win_q;
	logic [WIN_BITS-1:0] win_next;
	logic [WIN_BITS-1:0] kept;
	logic [WIN_BITS-1:0] incoming;
	beat_data_t beat_in;
	fill_t fill_q;
	fill_t fill_rem;
	fill_t fill_next;
	fill_t keep_cnt;
	logic accept;

	// room for a full beat only while at most half full
	assign axis_ready_o = (fill_q <= fill_t'(`MOLD_BEAT_BYTES));
	assign accept = axis_valid_i & axis_ready_o;

	// tkeep is a thermometer, so its popcount is the byte count
	always_comb begin
		keep_cnt = '0;
		beat_in = '0;
		for (int i = 0; i < `MOLD_BEAT_BYTES; i++) begin
			keep_cnt = keep_cnt + fill_t'(axis_keep_i[i]);
			if (axis_keep_i[i]) begin
				beat_in[8*i +: 8] = axis_data_i[8*i +: 8];
			end
		end
	end

	assign fill_rem = fill_q - fill_t'(take_i);

	// shift out the taken bytes and clear everything past the remainder
	always_comb begin
		kept = win_q >> {take_i, 3'b000};
		for (int i = 0; i < `MOLD_WIN_BYTES; i++) begin
			if (i >= int'(fill_rem)) begin
				kept[8*i +: 8] = 8'h00;
			end
		end
	end

	assign incoming = {{(WIN_BITS-BEAT_BITS){1'b0}}, beat_in} << {fill_rem, 3'b000};
	assign win_next = accept ? (kept | incoming) : kept;
	assign fill_next = fill_rem + (accept ? keep_cnt : fill_t'(0));

	always_ff @(posedge clk) begin
		if (!nreset) begin
			fill_q <= '0;
		end else begin
			fill_q <= fill_next;
		end
	end

	always_ff @(posedge clk) begin
		win_q <= win_next;
	end

	assign head_o = win_q[`MOLD_HEAD_BYTES*8-1:0];
	assign fill_o = fill_q;

	a_fill_cap: assert property (@(posedge clk) disable iff (!nreset)
		fill_q <= fill_t'(`MOLD_WIN_BYTES));
	a_take_le_fill: assert property (@(posedge clk) disable iff (!nreset)
		fill_t'(take_i) <= fill_q);
	a_keep_thermo: assert property (@(posedge clk) disable iff (!nreset)
		axis_valid_i |-> ((axis_keep_i & (axis_keep_i + 1'b1)) == '0));

endmodule

`default_nettype wire

// File: hdl/field_sequencer.sv
/*
 * Header and message FSM of the MoldUDP64 parser.
 * Walks session id, sequence number and message count, then
 * alternates message length and payload chunks, and tells the
 * byte window how many head bytes to drop each cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "mold_cfg.svh"

module field_sequencer (
	input wire clk,
	input wire nreset,
	input wire mold_pkg::head_t head_i,
	input wire mold_pkg::fill_t fill_i,
	output mold_pkg::take_t take_o,
	field_if.seq fld
);
	import mold_pkg::*;

	seq_state_t state_q;
	seq_state_t state_next;
	len_t cnt_q;
	len_t cnt_next;
	len_t len_q;
	len_t len_next;
	logic first_q;
	logic first_next;
	len_t head_word;
	take_t chunk;
	logic chunk_end;

	// count and length fields are big-endian, byte 0 is the msb
	assign head_word = {head_i[7:0], head_i[15:8]};

	// payload chunk is the lesser of the remaining length and one beat
	assign chunk_end = (len_q <= len_t'(`MOLD_BEAT_BYTES));
	assign chunk = chunk_end ? take_t'(len_q) : take_t'(`MOLD_BEAT_BYTES);

	assign fld.head = head_i;

	always_comb begin
		state_next = state_q;
		cnt_next = cnt_q;
		len_next = len_q;
		first_next = first_q;
		take_o = '0;
		fld.sid_v = 1'b0;
		fld.seq_v = 1'b0;
		fld.chunk_v = 1'b0;
		fld.chunk_len = '0;
		fld.chunk_first = 1'b0;
		fld.chunk_last = 1'b0;
		fld.eos_v = 1'b0;
		case (state_q)
			SID: if (fill_i >= fill_t'(`MOLD_SID_BYTES)) begin
				take_o = take_t'(`MOLD_SID_BYTES);
				fld.sid_v = 1'b1;
				state_next = SEQ;
			end
			SEQ: if (fill_i >= fill_t'(`MOLD_SEQ_BYTES)) begin
				take_o = take_t'(`MOLD_SEQ_BYTES);
				fld.seq_v = 1'b1;
				state_next = CNT;
			end
			CNT: if (fill_i >= fill_t'(`MOLD_CNT_BYTES)) begin
				take_o = take_t'(`MOLD_CNT_BYTES);
				cnt_next = head_word;
				// heartbeat and end of session carry no messages
				if (head_word == len_t'(`MOLD_EOS_CNT)) begin
					fld.eos_v = 1'b1;
					state_next = SID;
				end else if (head_word == '0) begin
					state_next = SID;
				end else begin
					state_next = LEN;
				end
			end
			LEN: if (fill_i >= fill_t'(`MOLD_LEN_BYTES)) begin
				take_o = take_t'(`MOLD_LEN_BYTES);
				len_next = head_word;
				first_next = 1'b1;
				state_next = PAYLOAD;
			end
			PAYLOAD: if (fill_i >= fill_t'(chunk)) begin
				take_o = chunk;
				fld.chunk_v = 1'b1;
				fld.chunk_len = chunk;
				fld.chunk_first = first_q;
				fld.chunk_last = chunk_end;
				len_next = len_q - len_t'(chunk);
				first_next = 1'b0;
				if (chunk_end) begin
					cnt_next = cnt_q - len_t'(1);
					state_next = (cnt_q == len_t'(1)) ? SID : LEN;
				end
			end
			default: state_next = SID;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state_q <= SID;
			cnt_q <= '0;
			len_q <= '0;
			first_q <= 1'b0;
		end else begin
			state_q <= state_next;
			cnt_q <= cnt_next;
			len_q <= len_next;
			first_q <= first_next;
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!nreset)
		state_q inside {SID, SEQ, CNT, LEN, PAYLOAD});
	// every field strobe consumes head bytes, a zero-length message breaks this
	a_take_strobe: assert property (@(posedge clk) disable iff (!nreset)
		(fld.sid_v | fld.seq_v | fld.chunk_v) |-> (take_o != '0));

endmodule

`default_nettype wire

// File: hdl/session_tracker.sv
/*
 * Session id and message sequence number tracker.
 * Loads both from the big-endian header bytes at the window head
 * and steps the sequence number after each message's last chunk
 */
`timescale 1ns/1ps
`default_nettype none

`include "mold_cfg.svh"

module session_tracker (
	input wire clk,
	input wire nreset,
	field_if.tracker fld,
	output mold_pkg::sid_t sid_o,
	output mold_pkg::seq_t seq_o
);
	import mold_pkg::*;

	sid_t sid_q;
	seq_t seq_q;
	sid_t sid_be;
	seq_t seq_be;

	// head byte 0 is the most significant byte of each field
	always_comb begin
		for (int i = 0; i < `MOLD_SID_BYTES; i++) begin
			sid_be[8*i +: 8] = fld.head[8*(`MOLD_SID_BYTES-1-i) +: 8];
		end
		for (int i = 0; i < `MOLD_SEQ_BYTES; i++) begin
			seq_be[8*i +: 8] = fld.head[8*(`MOLD_SEQ_BYTES-1-i) +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sid_q <= '0;
			seq_q <= '0;
		end else begin
			if (fld.sid_v) begin
				sid_q <= sid_be;
			end
			// the emitter samples the old value on the last chunk's edge
			if (fld.seq_v) begin
				seq_q <= seq_be;
			end else if (fld.chunk_last) begin
				seq_q <= seq_q + seq_t'(1);
			end
		end
	end

	assign sid_o = sid_q;
	assign seq_o = seq_q;

endmodule

`default_nettype wire

// File: hdl/payload_slicer.sv
/*
 * Output beat slicer.
 * Takes the first eight window head bytes as the beat, builds a
 * thermometer lane mask from the chunk length and zeroes unused lanes
 */
`timescale 1ns/1ps
`default_nettype none

`include "mold_cfg.svh"

module payload_slicer (
	field_if.slicer fld,
	output mold_pkg::beat_data_t data_o,
	output mold_pkg::beat_mask_t mask_o
);

	// lanes below chunk_len are valid, mask is empty without a chunk
	always_comb begin
		mask_o = '0;
		for (int i = 0; i < `MOLD_BEAT_BYTES; i++) begin
			if (fld.chunk_v && (i < fld.chunk_len)) begin
				mask_o[i] = 1'b1;
			end
		end
	end

	// message byte 0 is already in lane 0 at the head
	always_comb begin
		data_o = '0;
		for (int i = 0; i < `MOLD_BEAT_BYTES; i++) begin
			if (mask_o[i]) begin
				data_o[8*i +: 8] = fld.head[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/msg_emitter.sv
/*
 * Output register stage of the parser.
 * Registers the sliced beat, session id, sequence number and the
 * start, last and end-of-session flags onto the message outputs
 */
`timescale 1ns/1ps
`default_nettype none

module msg_emitter (
	input wire clk,
	input wire nreset,
	field_if.emit fld,
	input wire mold_pkg::beat_data_t data_i,
	input wire mold_pkg::beat_mask_t mask_i,
	input wire mold_pkg::sid_t sid_i,
	input wire mold_pkg::seq_t seq_i,
	output logic mold_v_o,
	output logic mold_start_o,
	output logic mold_last_o,
	output mold_pkg::beat_mask_t mold_mask_o,
	output mold_pkg::beat_data_t mold_data_o,
	output mold_pkg::sid_t mold_sid_o,
	output mold_pkg::seq_t mold_seq_o,
	output logic mold_eos_o
);

	// strobes
	always_ff @(posedge clk) begin
		if (!nreset) begin
			mold_v_o <= 1'b0;
			mold_start_o <= 1'b0;
			mold_last_o <= 1'b0;
			mold_eos_o <= 1'b0;
		end else begin
			mold_v_o <= fld.chunk_v;
			mold_start_o <= fld.chunk_v & fld.chunk_first;
			mold_last_o <= fld.chunk_last;
			mold_eos_o <= fld.eos_v;
		end
	end

	// beat and ids, sid also qualifies the eos strobe
	always_ff @(posedge clk) begin
		mold_data_o <= data_i;
		mold_mask_o <= mask_i;
		mold_sid_o <= sid_i;
		mold_seq_o <= seq_i;
	end

	a_last_has_valid: assert property (@(posedge clk) disable iff (!nreset)
		mold_last_o |-> mold_v_o);

endmodule

`default_nettype wire

// File: hdl/moldudp64_top.sv
/*
 * MoldUDP64 parser top level.
 * AXI-stream bytes enter a byte window, a field FSM walks the header
 * and messages, and the tracker, slicer and emitter form the beats
 */
`timescale 1ns/1ps
`default_nettype none

module moldudp64_top (
	input wire clk,
	input wire nreset,
	input wire udp_axis_tvalid_i,
	input wire mold_pkg::beat_mask_t udp_axis_tkeep_i,
	input wire mold_pkg::beat_data_t udp_axis_tdata_i,
	output logic udp_axis_tready_o,
	output logic mold_v_o,
	output logic mold_start_o,
	output logic mold_last_o,
	output mold_pkg::beat_mask_t mold_mask_o,
	output mold_pkg::beat_data_t mold_data_o,
	output mold_pkg::sid_t mold_sid_o,
	output mold_pkg::seq_t mold_seq_o,
	output logic mold_eos_o
);
	import mold_pkg::*;

	head_t head;
	fill_t fill;
	take_t take;
	sid_t sid;
	seq_t seq;
	beat_data_t slice_data;
	beat_mask_t slice_mask;

	field_if fld ();

	byte_window u_window (
		.clk(clk),
		.nreset(nreset),
		.axis_valid_i(udp_axis_tvalid_i),
		.axis_keep_i(udp_axis_tkeep_i),
		.axis_data_i(udp_axis_tdata_i),
		.take_i(take),
		.axis_ready_o(udp_axis_tready_o),
		.head_o(head),
		.fill_o(fill)
	);

	field_sequencer u_sequencer (
		.clk(clk),
		.nreset(nreset),
		.head_i(head),
		.fill_i(fill),
		.take_o(take),
		.fld(fld.seq)
	);

	session_tracker u_tracker (
		.clk(clk),
		.nreset(nreset),
		.fld(fld.tracker),
		.sid_o(sid),
		.seq_o(seq)
	);

	payload_slicer u_slicer (
		.fld(fld.slicer),
		.data_o(slice_data),
		.mask_o(slice_mask)
	);

	// outputs lag the sequencer's take by one cycle
	msg_emitter u_emitter (
		.clk(clk),
		.nreset(nreset),
		.fld(fld.emit),
		.data_i(slice_data),
		.mask_i(slice_mask),
		.sid_i(sid),
		.seq_i(seq),
		.mold_v_o(mold_v_o),
		.mold_start_o(mold_start_o),
		.mold_last_o(mold_last_o),
		.mold_mask_o(mold_mask_o),
		.mold_data_o(mold_data_o),
		.mold_sid_o(mold_sid_o),
		.mold_seq_o(mold_seq_o),
		.mold_eos_o(mold_eos_o)
	);

endmodule

`default_nettype wire

// File: bench/tb_tasks.svh
/*
 * Testbench tasks for the MoldUDP64 parser:
 * packet builder with expected beats, AXI beat driver, value check,
 * reset and the directed tests
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	integer seed = 1782;
	logic [7:0] pkt[$];
	int msg_len[$];
	logic [63:0] exp_data[$];
	logic [7:0] exp_mask[$];
	logic exp_start[$];
	logic exp_last[$];
	logic [79:0] exp_sid[$];
	logic [63:0] exp_seq[$];
	logic [79:0] exp_eos_sid[$];

	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic clear_expect;
		exp_data.delete();
		exp_mask.delete();
		exp_start.delete();
		exp_last.delete();
		exp_sid.delete();
		exp_seq.delete();
		exp_eos_sid.delete();
	endtask

	// split one message into beats of up to 8 bytes, message byte 0 in lane 0
	task automatic expect_message(input int start, input int len, input logic [79:0] sid,
		input logic [63:0] seq);
		int off;
		int n;
		int j;
		logic [63:0] data;
		logic [7:0] mask;
		off = 0;
		while (off < len) begin
			n = (len - off > 8) ? 8 : len - off;
			data = '0;
			mask = '0;
			for (j = 0; j < n; j++) begin
				data[8*j +: 8] = pkt[start + off + j];
				mask[j] = 1'b1;
			end
			exp_data.push_back(data);
			exp_mask.push_back(mask);
			exp_start.push_back(off == 0);
			exp_last.push_back(off + n == len);
			exp_sid.push_back(sid);
			exp_seq.push_back(seq);
			off += n;
		end
	endtask

	// header fields and lengths go out most significant byte first
	task automatic build_packet(input logic [79:0] sid, input logic [63:0] seq,
		input logic [15:0] count);
		int i;
		int m;
		int b;
		int start;
		logic [15:0] len;
		pkt.delete();
		for (i = 0; i < 10; i++) begin
			pkt.push_back(sid[8*(9-i) +: 8]);
		end
		for (i = 0; i < 8; i++) begin
			pkt.push_back(seq[8*(7-i) +: 8]);
		end
		pkt.push_back(count[15:8]);
		pkt.push_back(count[7:0]);
		if (count == 16'hffff) begin
			exp_eos_sid.push_back(sid);
		end else if (count != 16'h0000) begin
			for (m = 0; m < msg_len.size(); m++) begin
				len = 16'(msg_len[m]);
				pkt.push_back(len[15:8]);
				pkt.push_back(len[7:0]);
				start = pkt.size();
				for (b = 0; b < len; b++) begin
					pkt.push_back(8'($random(seed)));
				end
				expect_message(start, len, sid, seq + 64'(m));
			end
		end
	endtask

	// hold the beat until ready is seen before a rising edge
	task automatic send_beat(input logic [7:0] keep, input logic [63:0] data);
		logic ok;
		tvalid = 1'b1;
		tkeep = keep;
		tdata = data;
		ok = 1'b0;
		while (!ok) begin
			@(negedge clk);
			ok = tready;
			@(posedge clk);
			#1;
		end
		beats_driven++;
	endtask

	task automatic drive_packet(input int beat_limit);
		int i;
		int j;
		int beats;
		logic [7:0] keep;
		logic [63:0] data;
		i = 0;
		beats = 0;
		while (i < pkt.size() && beats < beat_limit) begin
			keep = '0;
			data = '0;
			for (j = 0; j < 8; j++) begin
				if (i + j < pkt.size()) begin
					data[8*j +: 8] = pkt[i + j];
					keep[j] = 1'b1;
				end
			end
			send_beat(keep, data);
			i += 8;
			beats++;
		end
	endtask

	task automatic idle_input;
		tvalid = 1'b0;
		tkeep = '0;
		tdata = '0;
	endtask

	task automatic wait_drain;
		while (exp_data.size() != 0 || exp_eos_sid.size() != 0) begin
			@(posedge clk);
		end
		// a few more cycles to catch stray beats
		repeat (8) @(posedge clk);
		#1;
	endtask

	task automatic reset_dut;
		nreset = 1'b0;
		idle_input();
		repeat (4) @(posedge clk);
		#1;
		check_value("valid in reset", mold_v, 1'b0);
		check_value("eos in reset", mold_eos, 1'b0);
		check_value("ready in reset", tready, 1'b1);
		nreset = 1'b1;
	endtask

	task automatic single_message;
		msg_len = '{5};
		build_packet(80'h4d4f4c44_53455353_3031, 64'h0000_0000_0000_0010, 16'd1);
		drive_packet(1000);
		idle_input();
		wait_drain();
	endtask

	task automatic three_messages;
		msg_len = '{20, 1, 9};
		build_packet(80'h4d4f4c44_53455353_3032, 64'h0000_0001_0000_0000, 16'd3);
		drive_packet(1000);
		idle_input();
		wait_drain();
	endtask

	// valid stays high across packet boundaries
	task automatic back_to_back;
		int p;
		int m;
		int n;
		for (p = 0; p < 4; p++) begin
			msg_len.delete();
			n = 1 + ($unsigned($random(seed)) % 4);
			for (m = 0; m < n; m++) begin
				msg_len.push_back(1 + ($unsigned($random(seed)) % 30));
			end
			build_packet(80'h4d4f4c44_53455353_3130 + 80'(p), 64'h200 + 64'(100 * p), 16'(n));
			drive_packet(1000);
		end
		idle_input();
		wait_drain();
	endtask

	task automatic heartbeat_skip;
		msg_len.delete();
		build_packet(80'h48454152_54424541_5431, 64'h0000_0000_0000_0300, 16'd0);
		drive_packet(1000);
		msg_len = '{3, 12};
		build_packet(80'h4d4f4c44_53455353_3033, 64'h0000_0000_0000_0301, 16'd2);
		drive_packet(1000);
		idle_input();
		wait_drain();
	endtask

	task automatic end_of_session;
		msg_len.delete();
		build_packet(80'h454e4453_45535349_4f4e, 64'h0000_0000_0000_0400, 16'hffff);
		drive_packet(1000);
		msg_len = '{7};
		build_packet(80'h4d4f4c44_53455353_3034, 64'h0000_0000_0000_0401, 16'd1);
		drive_packet(1000);
		idle_input();
		wait_drain();
	endtask

	// three beats reach only two payload bytes, so no beat comes out
	task automatic reset_mid_packet;
		msg_len = '{30};
		build_packet(80'h41424f52_54454453_4944, 64'h0000_0000_0000_0500, 16'd1);
		clear_expect();
		drive_packet(3);
		reset_dut();
		msg_len = '{11};
		build_packet(80'h4d4f4c44_53455353_3035, 64'h0000_0000_0000_0600, 16'd1);
		drive_packet(1000);
		idle_input();
		wait_drain();
	endtask

`endif

// File: bench/tb_moldudp64.sv
/*
 * Testbench for the MoldUDP64 parser:
 * clock and reset, DUT instance, output monitor against the
 * expectation queues, cycle timeout and the closing summary
 */
`timescale 1ns/1ps
`default_nettype none

module tb_moldudp64;

	logic clk;
	logic nreset;
	logic tvalid;
	logic [7:0] tkeep;
	logic [63:0] tdata;
	logic tready;
	logic mold_v;
	logic mold_start;
	logic mold_last;
	logic [7:0] mold_mask;
	logic [63:0] mold_data;
	logic [79:0] mold_sid;
	logic [63:0] mold_seq;
	logic mold_eos;

	int err_count = 0;
	int check_count = 0;
	int beats_driven = 0;
	int cycle_count = 0;
	int win_model = 0;

	moldudp64_top dut0 (
		.clk(clk),
		.nreset(nreset),
		.udp_axis_tvalid_i(tvalid),
		.udp_axis_tkeep_i(tkeep),
		.udp_axis_tdata_i(tdata),
		.udp_axis_tready_o(tready),
		.mold_v_o(mold_v),
		.mold_start_o(mold_start),
		.mold_last_o(mold_last),
		.mold_mask_o(mold_mask),
		.mold_data_o(mold_data),
		.mold_sid_o(mold_sid),
		.mold_seq_o(mold_seq),
		.mold_eos_o(mold_eos)
	);

	`include "tb_tasks.svh"

	always #50 clk = ~clk;

	// bytes held in the window, from accepted beats and the sequencer's take
	always @(posedge clk) begin
		if (!nreset) begin
			win_model <= 0;
		end else begin
			win_model <= win_model - int'(dut0.take) +
				((tvalid && tready) ? $countones(tkeep) : 0);
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (nreset) begin
			check_value("ready against window fill", tready, win_model <= 8);
			if (mold_v) begin
				if (exp_data.size() == 0) begin
					err_count++;
					$display("unexpected output beat at %0t ns, none was expected", $time);
				end else begin
					check_value("beat data", mold_data, exp_data.pop_front());
					check_value("beat mask", mold_mask, exp_mask.pop_front());
					check_value("start flag", mold_start, exp_start.pop_front());
					check_value("last flag", mold_last, exp_last.pop_front());
					check_value("beat sid", mold_sid, exp_sid.pop_front());
					check_value("beat seq", mold_seq, exp_seq.pop_front());
				end
			end
			if (mold_eos) begin
				if (exp_eos_sid.size() == 0) begin
					err_count++;
					$display("unexpected end-of-session strobe at %0t ns", $time);
				end else begin
					check_value("eos sid", mold_sid, exp_eos_sid.pop_front());
				end
			end
		end
	end

	// limit grows with every beat that the driver gets accepted
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > 20 * beats_driven + 200) begin
			$display("timeout after %0d cycles, the parser or the driver stopped making progress",
				cycle_count);
			$display("checks: %0d, errors: %0d", check_count, err_count + 1);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		nreset = 1'b0;
		tvalid = 1'b0;
		tkeep = '0;
		tdata = '0;
		reset_dut();
		single_message();
		three_messages();
		back_to_back();
		heartbeat_skip();
		end_of_session();
		reset_mid_packet();
		if (exp_data.size() != 0 || exp_eos_sid.size() != 0) begin
			err_count++;
			$display("%0d output beats and %0d eos strobes were expected but never came out",
				exp_data.size(), exp_eos_sid.size());
		end
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
+incdir+bench
hdl/mold_pkg.sv
hdl/field_if.sv
hdl/byte_window.sv
hdl/field_sequencer.sv
hdl/session_tracker.sv
hdl/payload_slicer.sv
hdl/msg_emitter.sv
hdl/moldudp64_top.sv
bench/tb_moldudp64.sv

// File: Bender.yml
package:
  name: moldudp64

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mold_pkg.sv
      - hdl/field_if.sv
      - hdl/byte_window.sv
      - hdl/field_sequencer.sv
      - hdl/session_tracker.sv
      - hdl/payload_slicer.sv
      - hdl/msg_emitter.sv
      - hdl/moldudp64_top.sv
  - target: test
    include_dirs:
      - hdl
      - bench
    files:
      - bench/tb_moldudp64.sv
